// ==== rtl/cpuPkg.sv ====
/* Shared widths, instruction field positions, opcode, ALU and branch codes,
   and the payload structs carried between the pipeline stages */
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 8;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [2:0] regIdxT;

	// instruction word fields
	localparam int opMsb = 15;
	localparam int opLsb = 11;
	localparam int rsMsb = 10;
	localparam int rsLsb = 8;
	localparam int rtMsb = 7;
	localparam int rtLsb = 5;
	localparam int rdRMsb = 4;
	localparam int rdRLsb = 2;
	localparam int fnMsb = 1;
	localparam int fnLsb = 0;
	localparam int rdIMsb = 7;
	localparam int rdILsb = 5;

	// immediate widths, all starting at bit 0
	localparam int immIWidth = 5;
	localparam int immBWidth = 8;
	localparam int immJWidth = 11;

	typedef enum logic [4:0] {
		opHalt  = 5'b00000,
		opNop   = 5'b00001,
		opJ     = 5'b00100,
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opXori  = 5'b01010,
		opAndni = 5'b01011,
		opBeqz  = 5'b01100,
		opBnez  = 5'b01101,
		opLbi   = 5'b11000,
		opArith = 5'b11011
	} opcodeT;

	// function field of the R-type arithmetic group
	localparam logic [1:0] fnAdd = 2'b00;
	localparam logic [1:0] fnSub = 2'b01;
	localparam logic [1:0] fnXor = 2'b10;
	localparam logic [1:0] fnAndn = 2'b11;

	// bubble word, opcode NOP with zero operands
	localparam wordT nopWord = {opNop, 11'b0};

	// aluSub computes b - a, i.e. Rt - Rs or imm - Rs
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluXor,
		aluAndNot,
		aluPassB
	} aluOpT;

	typedef enum logic [1:0] {
		brNone,
		brIfZero,
		brIfNonZero,
		brAlways
	} brCondT;

	typedef struct packed {
		logic valid;
		wordT instr;
		wordT pcNext;
	} ifIdT;

	typedef struct packed {
		logic valid;
		logic isHalt;
		logic regWrite;
		aluOpT aluOp;
		logic useImm;
		brCondT brCond;
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		wordT opA;
		wordT opB;
		wordT imm;
		wordT pcNext;
	} idExT;

	typedef struct packed {
		logic valid;
		logic isHalt;
		logic regWrite;
		regIdxT rd;
		wordT result;
	} exWbT;

	typedef struct packed {
		logic take;
		wordT target;
	} redirectT;

endpackage

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/100ps
/* Program counter with redirect and halt hold, and the fetch/decode register */
module fetchUnit #(
	parameter cpuPkg::wordT resetPc = '0
) (
	input logic clk,
	input logic arstN,
	input cpuPkg::wordT instr,
	output cpuPkg::wordT instrAddr,
	input cpuPkg::redirectT redirect,
	input logic haltSeen,
	output cpuPkg::ifIdT ifId
);

	cpuPkg::wordT pc;
	cpuPkg::wordT pcPlus2;
	cpuPkg::wordT pcNext;
	cpuPkg::ifIdT ifIdNext;
	logic stopped;
	logic hold;

	assign instrAddr = pc;
	assign pcPlus2 = pc + cpuPkg::wordT'(2);
	assign hold = stopped | haltSeen;

	// redirect wins over the halt hold
	always_comb begin
		if (redirect.take)
			pcNext = redirect.target;
		else if (hold)
			pcNext = pc;
		else
			pcNext = pcPlus2;
	end

	// slot is a bubble when flushed or once halted
	always_comb begin
		ifIdNext.valid = ~(redirect.take | hold);
		ifIdNext.instr = ifIdNext.valid ? instr : cpuPkg::nopWord;
		ifIdNext.pcNext = pcPlus2;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
			stopped <= 1'b0;
			ifId <= '{valid: 1'b0, instr: cpuPkg::nopWord, pcNext: '0};
		end else begin
			pc <= pcNext;
			ifId <= ifIdNext;
			if (redirect.take)
				stopped <= 1'b0;
			else if (haltSeen)
				stopped <= 1'b1;
		end
	end

endmodule

// ==== rtl/decodeUnit.sv ====
`timescale 1ns/100ps
/* Opcode decode, immediate extension and the decode/execute register */
module decodeUnit (
	input logic clk,
	input logic arstN,
	input cpuPkg::ifIdT ifId,
	input logic flush,
	output cpuPkg::regIdxT rs,
	output cpuPkg::regIdxT rt,
	input cpuPkg::wordT rdA,
	input cpuPkg::wordT rdB,
	output logic haltSeen,
	output cpuPkg::idExT idEx
);

	cpuPkg::opcodeT opcode;
	logic [1:0] fn;
	cpuPkg::wordT immI;
	cpuPkg::wordT immIZero;
	cpuPkg::wordT immB;
	cpuPkg::wordT immJ;
	cpuPkg::idExT idExNext;

	assign opcode = cpuPkg::opcodeT'(ifId.instr[cpuPkg::opMsb:cpuPkg::opLsb]);
	assign fn = ifId.instr[cpuPkg::fnMsb:cpuPkg::fnLsb];
	assign rs = ifId.instr[cpuPkg::rsMsb:cpuPkg::rsLsb];
	assign rt = ifId.instr[cpuPkg::rtMsb:cpuPkg::rtLsb];

	assign haltSeen = ifId.valid && (opcode == cpuPkg::opHalt);

	// sign extend except for the logic immediates
	assign immI = cpuPkg::wordT'($signed(ifId.instr[cpuPkg::immIWidth-1:0]));
	assign immIZero = cpuPkg::wordT'(ifId.instr[cpuPkg::immIWidth-1:0]);
	assign immB = cpuPkg::wordT'($signed(ifId.instr[cpuPkg::immBWidth-1:0]));
	assign immJ = cpuPkg::wordT'($signed(ifId.instr[cpuPkg::immJWidth-1:0]));

	always_comb begin
		idExNext = '0;
		idExNext.valid = ifId.valid;
		idExNext.aluOp = cpuPkg::aluAdd;
		idExNext.brCond = cpuPkg::brNone;
		idExNext.rs = rs;
		idExNext.rt = rt;
		idExNext.rd = ifId.instr[cpuPkg::rdIMsb:cpuPkg::rdILsb];
		idExNext.opA = rdA;
		idExNext.opB = rdB;
		idExNext.pcNext = ifId.pcNext;

		case (opcode)
			cpuPkg::opHalt: begin
				idExNext.isHalt = 1'b1;
			end
			cpuPkg::opAddi, cpuPkg::opSubi: begin
				idExNext.regWrite = 1'b1;
				idExNext.useImm = 1'b1;
				idExNext.imm = immI;
				if (opcode == cpuPkg::opSubi)
					idExNext.aluOp = cpuPkg::aluSub;
			end
			cpuPkg::opXori, cpuPkg::opAndni: begin
				idExNext.regWrite = 1'b1;
				idExNext.useImm = 1'b1;
				idExNext.imm = immIZero;
				if (opcode == cpuPkg::opXori)
					idExNext.aluOp = cpuPkg::aluXor;
				else
					idExNext.aluOp = cpuPkg::aluAndNot;
			end
			cpuPkg::opArith: begin
				idExNext.regWrite = 1'b1;
				idExNext.rd = ifId.instr[cpuPkg::rdRMsb:cpuPkg::rdRLsb];
				case (fn)
					cpuPkg::fnAdd: idExNext.aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: idExNext.aluOp = cpuPkg::aluSub;
					cpuPkg::fnXor: idExNext.aluOp = cpuPkg::aluXor;
					default: idExNext.aluOp = cpuPkg::aluAndNot;
				endcase
			end
			cpuPkg::opBeqz: begin
				idExNext.brCond = cpuPkg::brIfZero;
				idExNext.imm = immB;
			end
			cpuPkg::opBnez: begin
				idExNext.brCond = cpuPkg::brIfNonZero;
				idExNext.imm = immB;
			end
			cpuPkg::opLbi: begin
				// LBI targets the register in the rs field
				idExNext.regWrite = 1'b1;
				idExNext.rd = rs;
				idExNext.useImm = 1'b1;
				idExNext.imm = immB;
				idExNext.aluOp = cpuPkg::aluPassB;
			end
			cpuPkg::opJ: begin
				idExNext.brCond = cpuPkg::brAlways;
				idExNext.imm = immJ;
			end
			// NOP and unknown opcodes do nothing
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			idEx <= '0;
		else if (flush || !ifId.valid)
			idEx <= '0;
		else
			idEx <= idExNext;
	end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/100ps
/* Eight-entry register file, two read ports, one write port, write bypass */
module regFile (
	input logic clk,
	input logic arstN,
	input cpuPkg::regIdxT rs,
	input cpuPkg::regIdxT rt,
	output cpuPkg::wordT rdA,
	output cpuPkg::wordT rdB,
	input logic wrEn,
	input cpuPkg::regIdxT wrReg,
	input cpuPkg::wordT wrData
);

	cpuPkg::wordT regs [cpuPkg::regCount];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < cpuPkg::regCount; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrReg] <= wrData;
		end
	end

	// same-cycle write shows up on the read ports
	assign rdA = (wrEn && (wrReg == rs)) ? wrData : regs[rs];
	assign rdB = (wrEn && (wrReg == rt)) ? wrData : regs[rt];

endmodule

// ==== rtl/executeUnit.sv ====
`timescale 1ns/100ps
/* Operand forwarding, ALU, branch and jump resolution,
   execute/writeback register and the halted flag */
module executeUnit (
	input logic clk,
	input logic arstN,
	input cpuPkg::idExT idEx,
	output cpuPkg::redirectT redirect,
	output logic flush,
	output cpuPkg::exWbT exWb,
	output logic halted
);

	cpuPkg::wordT srcA;
	cpuPkg::wordT srcB;
	cpuPkg::wordT aluB;
	cpuPkg::wordT result;
	logic fwdA;
	logic fwdB;
	logic isZero;
	logic take;
	logic haltSticky;

	// older instruction in writeback overrides the decode-time read
	assign fwdA = exWb.valid && exWb.regWrite && (exWb.rd == idEx.rs);
	assign fwdB = exWb.valid && exWb.regWrite && (exWb.rd == idEx.rt);
	assign srcA = fwdA ? exWb.result : idEx.opA;
	assign srcB = fwdB ? exWb.result : idEx.opB;
	assign aluB = idEx.useImm ? idEx.imm : srcB;

	always_comb begin
		case (idEx.aluOp)
			cpuPkg::aluAdd: result = srcA + aluB;
			cpuPkg::aluSub: result = aluB - srcA;
			cpuPkg::aluXor: result = srcA ^ aluB;
			cpuPkg::aluAndNot: result = srcA & ~aluB;
			default: result = aluB;
		endcase
	end

	// branches test the forwarded rs value
	assign isZero = (srcA == '0);

	always_comb begin
		case (idEx.brCond)
			cpuPkg::brIfZero: take = idEx.valid & isZero;
			cpuPkg::brIfNonZero: take = idEx.valid & ~isZero;
			cpuPkg::brAlways: take = idEx.valid;
			default: take = 1'b0;
		endcase
	end

	assign redirect.take = take;
	assign redirect.target = idEx.pcNext + idEx.imm;
	assign flush = take;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exWb <= '0;
		end else begin
			exWb.valid <= idEx.valid;
			exWb.isHalt <= idEx.valid & idEx.isHalt;
			exWb.regWrite <= idEx.valid & idEx.regWrite;
			exWb.rd <= idEx.rd;
			exWb.result <= result;
		end
	end

	// stays set until reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			haltSticky <= 1'b0;
		else if (exWb.valid && exWb.isHalt)
			haltSticky <= 1'b1;
	end

	assign halted = exWb.isHalt | haltSticky;

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/100ps
/* Four-stage core top: fetch, decode with register file, execute,
   writeback port and halt status */
module cpuCore #(
	parameter cpuPkg::wordT resetPc = '0
) (
	input logic clk,
	input logic arstN,
	output cpuPkg::wordT instrAddr,
	input cpuPkg::wordT instr,
	output logic wbEn,
	output cpuPkg::regIdxT wbReg,
	output cpuPkg::wordT wbData,
	output logic halted
);

	cpuPkg::ifIdT ifId;
	cpuPkg::idExT idEx;
	cpuPkg::exWbT exWb;
	cpuPkg::redirectT redirect;
	logic flush;
	logic haltSeen;
	cpuPkg::regIdxT rs;
	cpuPkg::regIdxT rt;
	cpuPkg::wordT rdA;
	cpuPkg::wordT rdB;

	fetchUnit #(
		.resetPc(resetPc)
	) fetchStage (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.instrAddr(instrAddr),
		.redirect(redirect),
		.haltSeen(haltSeen),
		.ifId(ifId)
	);

	decodeUnit decodeStage (
		.clk(clk),
		.arstN(arstN),
		.ifId(ifId),
		.flush(flush),
		.rs(rs),
		.rt(rt),
		.rdA(rdA),
		.rdB(rdB),
		.haltSeen(haltSeen),
		.idEx(idEx)
	);

	regFile regs (
		.clk(clk),
		.arstN(arstN),
		.rs(rs),
		.rt(rt),
		.rdA(rdA),
		.rdB(rdB),
		.wrEn(wbEn),
		.wrReg(wbReg),
		.wrData(wbData)
	);

	executeUnit executeStage (
		.clk(clk),
		.arstN(arstN),
		.idEx(idEx),
		.redirect(redirect),
		.flush(flush),
		.exWb(exWb),
		.halted(halted)
	);

	// writeback is the register file write of this cycle
	assign wbEn = exWb.valid & exWb.regWrite;
	assign wbReg = exWb.rd;
	assign wbData = exWb.result;

endmodule

// ==== bench/isaModel.svh ====
/* Encoders for the kept instruction subset and the in-order reference model
   that fills the queue of expected register writes */

// R-type arithmetic group, fn 00 add, 01 sub, 10 xor, 11 andn
function automatic logic [15:0] encR(input logic [1:0] fn, input logic [2:0] rs,
	input logic [2:0] rt, input logic [2:0] rd);
	return {5'b11011, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rs,
	input logic [2:0] rd, input logic [4:0] imm);
	return {op, rs, rd, imm};
endfunction

// LBI, BEQZ and BNEZ share the rs plus 8-bit immediate layout
function automatic logic [15:0] encRsImm(input logic [4:0] op, input logic [2:0] rs,
	input logic [7:0] imm);
	return {op, rs, imm};
endfunction

function automatic logic [15:0] encJ(input logic [10:0] imm);
	return {5'b00100, imm};
endfunction

// runs the program in imem from resetPc until HALT, all registers zero at start
task automatic runModel();
	logic [15:0] r [8];
	logic [15:0] pc;
	logic [15:0] w;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] val;
	logic [2:0] rd;
	logic wr;
	int steps;
	bit done;
	r = '{default: 16'h0};
	pc = resetPc;
	steps = 0;
	done = 1'b0;
	expQ.delete();
	while (!done) begin
		w = imem[pc[6:1]];
		a = r[w[10:8]];
		b = r[w[7:5]];
		pc = pc + 16'd2;
		wr = 1'b0;
		rd = w[7:5];
		val = 16'h0;
		case (w[15:11])
			5'b11011: begin
				wr = 1'b1;
				rd = w[4:2];
				case (w[1:0])
					2'b00: val = a + b;
					2'b01: val = b - a;
					2'b10: val = a ^ b;
					default: val = a & ~b;
				endcase
			end
			5'b01000: begin
				wr = 1'b1;
				val = a + {{11{w[4]}}, w[4:0]};
			end
			5'b01001: begin
				wr = 1'b1;
				val = {{11{w[4]}}, w[4:0]} - a;
			end
			5'b01010: begin
				wr = 1'b1;
				val = a ^ {11'b0, w[4:0]};
			end
			5'b01011: begin
				wr = 1'b1;
				val = a & ~{11'b0, w[4:0]};
			end
			// LBI writes the register named by the rs field
			5'b11000: begin
				wr = 1'b1;
				rd = w[10:8];
				val = {{8{w[7]}}, w[7:0]};
			end
			5'b01100: begin
				if (a == 16'd0)
					pc = pc + {{8{w[7]}}, w[7:0]};
			end
			5'b01101: begin
				if (a != 16'd0)
					pc = pc + {{8{w[7]}}, w[7:0]};
			end
			5'b00100: pc = pc + {{5{w[10]}}, w[10:0]};
			5'b00000: done = 1'b1;
			default: begin
			end
		endcase
		if (wr) begin
			r[rd] = val;
			expQ.push_back({rd, val});
		end
		steps++;
		if (steps > memDepth)
			failRun("reference model did not reach HALT");
	end
endtask

// ==== bench/cpuTb.sv ====
`timescale 1ns/100ps
/* Core testbench with clock, reset, random programs, instruction memory,
   writeback checker against the reference model and a cycle limit */
module cpuTb;

	localparam cpuPkg::wordT resetPc = 16'h0010;
	localparam int progCount = 20;
	localparam int progLen = 48;
	localparam int memDepth = 64;
	// up to three slots per instruction plus reset and drain margin
	localparam int cycleLimit = progCount * ((progLen + 1) * 4 + 30);

	logic clk = 1'b0;
	logic arstN = 1'b0;
	cpuPkg::wordT instrAddr;
	cpuPkg::wordT instr;
	logic wbEn;
	cpuPkg::regIdxT wbReg;
	cpuPkg::wordT wbData;
	logic halted;

	logic [15:0] imem [memDepth];
	// expected writes as {rd, data}
	logic [18:0] expQ [$];
	logic [31:0] lfsrState = 32'h869405c4;
	int cycleCount = 0;

	cpuCore #(
		.resetPc(resetPc)
	) uut (
		.clk(clk),
		.arstN(arstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted)
	);

	// same-cycle instruction memory
	assign instr = imem[instrAddr[6:1]];

	initial begin
		forever #5 clk = ~clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			failRun($sformatf("error at %0d ns: %s is %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++)
			v = {v[30:0], nextBit()};
		return v;
	endfunction

	`include "isaModel.svh"

	task automatic buildProgram();
		logic [3:0] kind;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		int span;
		int hop;
		int base;
		base = int'(resetPc[6:1]);
		// filler is a per-address ADDI that shows up as a stray write if fetched
		for (int i = 0; i < memDepth; i++)
			imem[6'(i)] = 16'h4000 | 16'(i);
		for (int i = 0; i < progLen; i++) begin
			kind = 4'(randBits(4));
			rs = 3'(randBits(3));
			rt = 3'(randBits(3));
			rd = 3'(randBits(3));
			// forward hop that lands at most on the HALT
			span = progLen - 1 - i;
			hop = int'(randBits(3));
			if (hop > span)
				hop = span;
			case (kind)
				4'd0, 4'd1, 4'd2, 4'd3, 4'd15:
					imem[6'(base + i)] = encR(2'(randBits(2)), rs, rt, rd);
				4'd4, 4'd5, 4'd6, 4'd7:
					imem[6'(base + i)] = encI({3'b010, 2'(randBits(2))}, rs, rd,
						5'(randBits(5)));
				4'd8, 4'd9: imem[6'(base + i)] = encRsImm(5'b11000, rs, 8'(randBits(8)));
				4'd10: imem[6'(base + i)] = encRsImm(5'b01100, rs, 8'(2 * hop));
				4'd11: imem[6'(base + i)] = encRsImm(5'b01101, rs, 8'(2 * hop));
				4'd12: imem[6'(base + i)] = encJ(11'(2 * hop));
				default: imem[6'(base + i)] = 16'h0800;
			endcase
		end
		imem[6'(base + progLen)] = 16'h0000;
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			failRun("timeout: the core did not halt within the cycle limit");
	end

	// writeback outputs are settled at the falling edge
	always @(negedge clk) begin
		if (arstN && wbEn) begin
			if (expQ.size() == 0) begin
				failRun("register write seen after the model ran out of writes");
			end else begin
				compare(32'(wbReg), 32'(expQ[0][18:16]), "wbReg");
				compare(32'(wbData), 32'(expQ[0][15:0]), "wbData");
				void'(expQ.pop_front());
			end
		end
	end

	initial begin
		for (int p = 0; p < progCount; p++) begin
			buildProgram();
			@(posedge clk);
			arstN <= 1'b0;
			@(negedge clk);
			runModel();
			compare(32'(wbEn), 32'd0, "wbEn in reset");
			compare(32'(halted), 32'd0, "halted in reset");
			compare(32'(instrAddr), 32'(resetPc), "instrAddr in reset");
			repeat (4) @(posedge clk);
			arstN <= 1'b1;
			// run until HALT reaches writeback
			do begin
				@(negedge clk);
			end while (!halted);
			compare(32'(expQ.size()), 32'd0, "expected writes left at halt");
			repeat (4) begin
				@(negedge clk);
				compare(32'(halted), 32'd1, "halted after HALT");
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+bench
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/cpuCore.sv
bench/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpuTb
OBJ_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --timing
PASS_MSG ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
